//--- hdl/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // byte address, virtual toward the core and physical on cbus
    typedef logic [31:0] addr_t;

    // one data word on any port
    typedef logic [31:0] word_t;

    // byte write enables
    // any bit set turns the access into a write
    typedef logic [3:0] strobe_t;

    // access size code
    typedef logic [2:0] size_t;

    // cbus burst length, beats minus one
    typedef logic [3:0] len_t;

    // top address bits picking the segment
    typedef logic [2:0] seg_t;

    // size encodings as seen on cbus
    localparam size_t SIZE_BYTE = 3'd0;
    localparam size_t SIZE_HALF = 3'd1;
    localparam size_t SIZE_WORD = 3'd2;

    // unmapped kernel segments, cached and uncached
    localparam seg_t SEG_KSEG0 = 3'b100;
    localparam seg_t SEG_KSEG1 = 3'b101;

    // uncached only, so every transfer is one beat
    localparam len_t LEN_SINGLE = 4'd0;

    // cbus owner
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_BUSY_FETCH,
        ARB_BUSY_DATA
    } arb_state_t;

    // which data port owns the data stream
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_PORT1,
        SEQ_PORT2
    } seq_state_t;

endpackage

`default_nettype wire

//--- hdl/ibus_to_cbus.sv
`timescale 1ns/1ps
`default_nettype none

module ibus_to_cbus (
    input  logic           clk,
    input  logic           rst_n,

    // fetch port from the core
    input  logic           ireq_valid,
    input  bus_pkg::addr_t ireq_addr,
    output logic           iresp_addr_ok,
    output logic           iresp_data_ok,
    output bus_pkg::word_t iresp_data,

    // fetch stream toward the arbiter
    output logic           f_valid,
    output bus_pkg::addr_t f_addr,
    output bus_pkg::size_t f_size,
    input  logic           f_done,
    input  bus_pkg::word_t f_rdata
);
    import bus_pkg::*;

    // high for the cycle right after a fetch retires
    logic ack_pending;

    // the core only sees its ack at the edge closing the done cycle
    // so the request it shows one cycle later may still be the old one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_pending <= 1'b0;
        end else begin
            ack_pending <= f_done;
        end
    end

    // hide the request while the ack is still settling
    // a real new fetch just waits one cycle
    assign f_valid = ireq_valid && !ack_pending;

    // address passes straight through
    // translation happens once, in the arbiter
    assign f_addr = ireq_addr;

    // instruction fetch is always a full word read
    assign f_size = SIZE_WORD;

    // uncached: address phase and data phase end together
    assign iresp_addr_ok = f_done;
    assign iresp_data_ok = f_done;

    // read data rides on the done cycle
    assign iresp_data = f_rdata;

endmodule

`default_nettype wire

//--- hdl/dbus_pair_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module dbus_pair_sequencer (
    input  logic             clk,
    input  logic             rst_n,

    // data port 1, older in program order
    input  logic             d1_req_valid,
    input  bus_pkg::addr_t   d1_req_addr,
    input  bus_pkg::size_t   d1_req_size,
    input  bus_pkg::strobe_t d1_req_strobe,
    input  bus_pkg::word_t   d1_req_data,
    output logic             d1_resp_addr_ok,
    output logic             d1_resp_data_ok,
    output bus_pkg::word_t   d1_resp_data,

    // data port 2, younger
    input  logic             d2_req_valid,
    input  bus_pkg::addr_t   d2_req_addr,
    input  bus_pkg::size_t   d2_req_size,
    input  bus_pkg::strobe_t d2_req_strobe,
    input  bus_pkg::word_t   d2_req_data,
    output logic             d2_resp_addr_ok,
    output logic             d2_resp_data_ok,
    output bus_pkg::word_t   d2_resp_data,

    // single in-order data stream toward the arbiter
    output logic             d_valid,
    output logic             d_is_write,
    output bus_pkg::addr_t   d_addr,
    output bus_pkg::size_t   d_size,
    output bus_pkg::strobe_t d_strobe,
    output bus_pkg::word_t   d_data,
    input  logic             d_done,
    input  bus_pkg::word_t   d_rdata
);
    import bus_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;
    logic       sel_p2;

    // port 2 only owns the stream in its own state
    assign sel_p2 = (state == SEQ_PORT2);

    // core holds each port until its ack, so fields are muxed, not copied
    assign d_valid  = (state != SEQ_IDLE);
    assign d_addr   = sel_p2 ? d2_req_addr   : d1_req_addr;
    assign d_size   = sel_p2 ? d2_req_size   : d1_req_size;
    assign d_strobe = sel_p2 ? d2_req_strobe : d1_req_strobe;
    assign d_data   = sel_p2 ? d2_req_data   : d1_req_data;

    // write whenever a byte lane is enabled
    assign d_is_write = |d_strobe;

    // port 1 first, always
    // port 2 follows once port 1 has fully retired, so a port 1 store
    // is visible to a port 2 load to the same word
    always_comb begin
        state_nxt = state;
        case (state)
            SEQ_IDLE: begin
                if (d1_req_valid) begin
                    state_nxt = SEQ_PORT1;
                end else if (d2_req_valid) begin
                    state_nxt = SEQ_PORT2;
                end
            end
            SEQ_PORT1: begin
                // pending port 2 goes straight on, one cycle after the ack
                if (d_done) begin
                    state_nxt = d2_req_valid ? SEQ_PORT2 : SEQ_IDLE;
                end
            end
            SEQ_PORT2: begin
                if (d_done) begin
                    state_nxt = SEQ_IDLE;
                end
            end
            default: begin
                state_nxt = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SEQ_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // one ack per request, on the done cycle of the owning port
    assign d1_resp_addr_ok = (state == SEQ_PORT1) && d_done;
    assign d1_resp_data_ok = (state == SEQ_PORT1) && d_done;
    assign d2_resp_addr_ok = sel_p2 && d_done;
    assign d2_resp_data_ok = sel_p2 && d_done;

    // read data is only meaningful alongside data_ok
    assign d1_resp_data = d_rdata;
    assign d2_resp_data = d_rdata;

endmodule

`default_nettype wire

//--- hdl/cbus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cbus_arbiter (
    input  logic             clk,
    input  logic             rst_n,

    // fetch stream, read only
    input  logic             f_valid,
    input  bus_pkg::addr_t   f_addr,
    input  bus_pkg::size_t   f_size,
    output logic             f_done,
    output bus_pkg::word_t   f_rdata,

    // data stream
    input  logic             d_valid,
    input  logic             d_is_write,
    input  bus_pkg::addr_t   d_addr,
    input  bus_pkg::size_t   d_size,
    input  bus_pkg::strobe_t d_strobe,
    input  bus_pkg::word_t   d_data,
    output logic             d_done,
    output bus_pkg::word_t   d_rdata,

    // cbus request
    output logic             creq_valid,
    output logic             creq_is_write,
    output bus_pkg::size_t   creq_size,
    output bus_pkg::addr_t   creq_addr,
    output bus_pkg::strobe_t creq_strobe,
    output bus_pkg::word_t   creq_data,
    output bus_pkg::len_t    creq_len,

    // cbus response
    input  logic             cresp_ready,
    input  logic             cresp_last,
    input  bus_pkg::word_t   cresp_data
);
    import bus_pkg::*;

    arb_state_t state;
    // on a tie, data goes first when set
    logic       prio_data;
    logic       grant_fetch;
    logic       grant_data;
    logic       beat_end;

    // fixed mapping, kseg0 and kseg1 fold onto physical zero
    function automatic addr_t xlate(input addr_t va);
        seg_t seg;
        seg = va[31:29];
        if (seg == SEG_KSEG0 || seg == SEG_KSEG1) begin
            xlate = {3'b000, va[28:0]};
        end else begin
            xlate = va;
        end
    endfunction

    // grant only from idle, the lock holds it otherwise
    always_comb begin
        grant_fetch = 1'b0;
        grant_data  = 1'b0;
        if (state == ARB_IDLE) begin
            if (f_valid && d_valid) begin
                grant_data  = prio_data;
                grant_fetch = !prio_data;
            end else begin
                grant_fetch = f_valid;
                grant_data  = d_valid;
            end
        end
    end

    // transfer ends on the last accepted beat
    assign beat_end = cresp_ready && cresp_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ARB_IDLE;
            prio_data <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (grant_fetch) begin
                        state <= ARB_BUSY_FETCH;
                    end else if (grant_data) begin
                        state <= ARB_BUSY_DATA;
                    end
                end
                ARB_BUSY_FETCH, ARB_BUSY_DATA: begin
                    if (beat_end) begin
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
            // loser of a tie wins the next one
            if (f_valid && d_valid && state == ARB_IDLE) begin
                prio_data <= grant_fetch;
            end
        end
    end

    // request fields captured once at grant, stable until last
    always_ff @(posedge clk) begin
        if (grant_fetch) begin
            creq_is_write <= 1'b0;
            creq_size     <= f_size;
            creq_addr     <= xlate(f_addr);
            creq_strobe   <= '0;
            creq_data     <= '0;
        end else if (grant_data) begin
            creq_is_write <= d_is_write;
            creq_size     <= d_size;
            creq_addr     <= xlate(d_addr);
            creq_strobe   <= d_strobe;
            creq_data     <= d_data;
        end
    end

    // valid straight from the state flops
    assign creq_valid = (state != ARB_IDLE);
    assign creq_len   = LEN_SINGLE;

    // completion goes back in the same cycle as the last beat
    assign f_done  = (state == ARB_BUSY_FETCH) && beat_end;
    assign d_done  = (state == ARB_BUSY_DATA) && beat_end;
    assign f_rdata = cresp_data;
    assign d_rdata = cresp_data;

endmodule

`default_nettype wire

//--- hdl/mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_top (
    input  logic             clk,
    input  logic             rst_n,

    // fetch port
    input  logic             ireq_valid,
    input  bus_pkg::addr_t   ireq_addr,
    output logic             iresp_addr_ok,
    output logic             iresp_data_ok,
    output bus_pkg::word_t   iresp_data,

    // data port 1
    input  logic             d1_req_valid,
    input  bus_pkg::addr_t   d1_req_addr,
    input  bus_pkg::size_t   d1_req_size,
    input  bus_pkg::strobe_t d1_req_strobe,
    input  bus_pkg::word_t   d1_req_data,
    output logic             d1_resp_addr_ok,
    output logic             d1_resp_data_ok,
    output bus_pkg::word_t   d1_resp_data,

    // data port 2
    input  logic             d2_req_valid,
    input  bus_pkg::addr_t   d2_req_addr,
    input  bus_pkg::size_t   d2_req_size,
    input  bus_pkg::strobe_t d2_req_strobe,
    input  bus_pkg::word_t   d2_req_data,
    output logic             d2_resp_addr_ok,
    output logic             d2_resp_data_ok,
    output bus_pkg::word_t   d2_resp_data,

    // shared memory bus
    output logic             creq_valid,
    output logic             creq_is_write,
    output bus_pkg::size_t   creq_size,
    output bus_pkg::addr_t   creq_addr,
    output bus_pkg::strobe_t creq_strobe,
    output bus_pkg::word_t   creq_data,
    output bus_pkg::len_t    creq_len,
    input  logic             cresp_ready,
    input  logic             cresp_last,
    input  bus_pkg::word_t   cresp_data
);
    import bus_pkg::*;

    // fetch stream
    logic    f_valid;
    addr_t   f_addr;
    size_t   f_size;
    logic    f_done;
    word_t   f_rdata;

    // data stream
    logic    d_valid;
    logic    d_is_write;
    addr_t   d_addr;
    size_t   d_size;
    strobe_t d_strobe;
    word_t   d_data;
    logic    d_done;
    word_t   d_rdata;

    ibus_to_cbus u_ifetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .ireq_valid    (ireq_valid),
        .ireq_addr     (ireq_addr),
        .iresp_addr_ok (iresp_addr_ok),
        .iresp_data_ok (iresp_data_ok),
        .iresp_data    (iresp_data),
        .f_valid       (f_valid),
        .f_addr        (f_addr),
        .f_size        (f_size),
        .f_done        (f_done),
        .f_rdata       (f_rdata)
    );

    // two data ports folded into one ordered stream
    dbus_pair_sequencer u_dseq (
        .clk             (clk),
        .rst_n           (rst_n),
        .d1_req_valid    (d1_req_valid),
        .d1_req_addr     (d1_req_addr),
        .d1_req_size     (d1_req_size),
        .d1_req_strobe   (d1_req_strobe),
        .d1_req_data     (d1_req_data),
        .d1_resp_addr_ok (d1_resp_addr_ok),
        .d1_resp_data_ok (d1_resp_data_ok),
        .d1_resp_data    (d1_resp_data),
        .d2_req_valid    (d2_req_valid),
        .d2_req_addr     (d2_req_addr),
        .d2_req_size     (d2_req_size),
        .d2_req_strobe   (d2_req_strobe),
        .d2_req_data     (d2_req_data),
        .d2_resp_addr_ok (d2_resp_addr_ok),
        .d2_resp_data_ok (d2_resp_data_ok),
        .d2_resp_data    (d2_resp_data),
        .d_valid         (d_valid),
        .d_is_write      (d_is_write),
        .d_addr          (d_addr),
        .d_size          (d_size),
        .d_strobe        (d_strobe),
        .d_data          (d_data),
        .d_done          (d_done),
        .d_rdata         (d_rdata)
    );

    cbus_arbiter u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .f_valid       (f_valid),
        .f_addr        (f_addr),
        .f_size        (f_size),
        .f_done        (f_done),
        .f_rdata       (f_rdata),
        .d_valid       (d_valid),
        .d_is_write    (d_is_write),
        .d_addr        (d_addr),
        .d_size        (d_size),
        .d_strobe      (d_strobe),
        .d_data        (d_data),
        .d_done        (d_done),
        .d_rdata       (d_rdata),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_size     (creq_size),
        .creq_addr     (creq_addr),
        .creq_strobe   (creq_strobe),
        .creq_data     (creq_data),
        .creq_len      (creq_len),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data)
    );

endmodule

`default_nettype wire

//--- verif/mem_top_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mem_top_sva (
    input wire logic                clk,
    input wire logic                rst_n,
    input wire logic                creq_valid,
    input wire logic                creq_is_write,
    input wire bus_pkg::size_t      creq_size,
    input wire bus_pkg::addr_t      creq_addr,
    input wire bus_pkg::strobe_t    creq_strobe,
    input wire bus_pkg::word_t      creq_data,
    input wire logic                cresp_ready,
    input wire logic                cresp_last,
    input wire logic                f_valid,
    input wire logic                d_valid,
    input wire logic                f_done,
    input wire logic                d_done,
    input wire bus_pkg::arb_state_t state
);
    import bus_pkg::*;

    // request fields frozen until the last beat
    a_cbus_stable: assert property (@(posedge clk) disable iff (!rst_n)
        creq_valid && !(cresp_ready && cresp_last) |=>
            creq_valid && $stable(creq_addr) && $stable(creq_is_write) &&
            $stable(creq_size) && $stable(creq_strobe) && $stable(creq_data))
        else $error("cbus request changed before its last beat");

    // done only while the stream still asks
    a_fetch_done: assert property (@(posedge clk) disable iff (!rst_n)
        f_done |-> f_valid)
        else $error("fetch done without a pending fetch");
    a_data_done: assert property (@(posedge clk) disable iff (!rst_n)
        d_done |-> d_valid)
        else $error("data done without a pending data access");

    // quiet bus coming out of reset
    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !creq_valid && !f_done && !d_done && state == ARB_IDLE)
        else $error("arbiter outputs active right after reset");

endmodule

bind cbus_arbiter mem_top_sva u_sva (.*);

`default_nettype wire

//--- verif/mem_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_top_tb;
    import bus_pkg::*;

    localparam int TIMEOUT = 200;

    logic clk;
    logic rst_n;
    logic ireq_valid, iresp_addr_ok, iresp_data_ok;
    addr_t ireq_addr;
    word_t iresp_data;
    logic d1_req_valid, d1_resp_addr_ok, d1_resp_data_ok;
    logic d2_req_valid, d2_resp_addr_ok, d2_resp_data_ok;
    addr_t d1_req_addr, d2_req_addr;
    size_t d1_req_size, d2_req_size;
    strobe_t d1_req_strobe, d2_req_strobe;
    word_t d1_req_data, d2_req_data, d1_resp_data, d2_resp_data;
    logic creq_valid, creq_is_write;
    size_t creq_size;
    addr_t creq_addr;
    strobe_t creq_strobe;
    word_t creq_data;
    len_t creq_len;

    // memory responses start quiet
    logic cresp_ready = 1'b0;
    logic cresp_last = 1'b0;
    word_t cresp_data = '0;

    // fields of the last request the slave accepted
    addr_t seen_addr;
    size_t seen_size;
    logic seen_write;

    // slave memory and the shadow copy by word address
    word_t mem [addr_t];
    word_t shadow [addr_t];
    logic slave_busy;
    int unsigned stall;

    // expected read data with a check flag in bit 32
    logic [32:0] exp_i [$];
    logic [32:0] exp_d1 [$];
    logic [32:0] exp_d2 [$];

    mem_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_size(input string name, input size_t got, input size_t exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_len(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    // default contents spread over the full word address
    function automatic word_t fill_word(input addr_t widx);
        return {widx[15:0], widx[31:16]} ^ 32'h9e37_79b9;
    endfunction

    // kseg0 and kseg1 lose their top three bits
    function automatic addr_t translate_addr(input addr_t va);
        if (va[31:29] == 3'b100 || va[31:29] == 3'b101) begin
            return {3'b000, va[28:0]};
        end
        return va;
    endfunction

    // reference read from the shadow
    function automatic word_t ref_read(input addr_t va);
        addr_t widx;
        widx = translate_addr(va) >> 2;
        return shadow.exists(widx) ? shadow[widx] : fill_word(widx);
    endfunction

    task automatic shadow_write(input addr_t va, input strobe_t st, input word_t w);
        word_t cur;
        cur = ref_read(va);
        for (int b = 0; b < 4; b++) begin
            if (st[b]) begin
                cur[8*b +: 8] = w[8*b +: 8];
            end
        end
        shadow[translate_addr(va) >> 2] = cur;
    endtask

    // any strobe bit makes a write
    task automatic verify_request(input addr_t va, input size_t sz, input strobe_t st);
        check_addr("creq_addr", seen_addr, translate_addr(va));
        check_flag("creq_is_write", seen_write, st != 0);
        check_size("creq_size", seen_size, sz);
    endtask

    // memory slave with 0 to 3 stall cycles
    always @(posedge clk or negedge rst_n) begin
        word_t cur;
        addr_t widx;
        if (!rst_n) begin
            cresp_ready <= 1'b0;
            cresp_last <= 1'b0;
            cresp_data <= '0;
            slave_busy <= 1'b0;
            stall <= 0;
        end else if (cresp_ready) begin
            cresp_ready <= 1'b0;
            cresp_last <= 1'b0;
            slave_busy <= 1'b0;
        end else if (creq_valid) begin
            if (!slave_busy) begin
                // single beat means zero in the len field
                check_len("creq_len", creq_len, len_t'(0));
                slave_busy <= 1'b1;
                stall <= $urandom % 4;
                seen_addr <= creq_addr;
                seen_size <= creq_size;
                seen_write <= creq_is_write;
            end else if (stall == 0) begin
                widx = creq_addr >> 2;
                cur = mem.exists(widx) ? mem[widx] : fill_word(widx);
                for (int b = 0; b < 4; b++) begin
                    if (creq_strobe[b]) begin
                        cur[8*b +: 8] = creq_data[8*b +: 8];
                    end
                end
                mem[widx] = cur;
                cresp_data <= cur;
                cresp_ready <= 1'b1;
                cresp_last <= 1'b1;
            end else begin
                stall <= stall - 1;
            end
        end
    end

    // compares responses at the falling edge where outputs are settled
    always @(negedge clk) begin
        logic [32:0] e;
        // addr_ok and data_ok rise together on every port
        if (iresp_addr_ok !== iresp_data_ok) begin
            fail_now("fetch addr_ok and data_ok out of step");
        end
        if (d1_resp_addr_ok !== d1_resp_data_ok) begin
            fail_now("port 1 addr_ok and data_ok out of step");
        end
        if (d2_resp_addr_ok !== d2_resp_data_ok) begin
            fail_now("port 2 addr_ok and data_ok out of step");
        end
        if (iresp_data_ok) begin
            if (exp_i.size() == 0) fail_now("fetch data_ok with no fetch outstanding");
            e = exp_i.pop_front();
            if (e[32]) check_word("iresp_data", iresp_data, e[31:0]);
        end
        if (d1_resp_data_ok) begin
            if (exp_d1.size() == 0) fail_now("port 1 data_ok with no request outstanding");
            e = exp_d1.pop_front();
            if (e[32]) check_word("d1_resp_data", d1_resp_data, e[31:0]);
        end
        if (d2_resp_data_ok) begin
            if (exp_d2.size() == 0) fail_now("port 2 data_ok with no request outstanding");
            e = exp_d2.pop_front();
            if (e[32]) check_word("d2_resp_data", d2_resp_data, e[31:0]);
        end
    end

    task automatic issue_fetch(input addr_t va, input bit chk_bus);
        int n;
        exp_i.push_back({1'b1, ref_read(va)});
        @(posedge clk);
        ireq_valid <= 1'b1;
        ireq_addr <= va;
        n = 0;
        do begin
            @(negedge clk);
            if (++n > TIMEOUT) fail_now("timeout waiting for fetch data_ok");
        end while (!iresp_data_ok);
        // fetch is a word read
        if (chk_bus) verify_request(va, SIZE_WORD, 4'h0);
        @(posedge clk);
        ireq_valid <= 1'b0;
    endtask

    task automatic access_ports(input bit chk_bus,
                                input bit use1, input addr_t a1, input size_t s1,
                                input strobe_t st1, input word_t w1,
                                input bit use2, input addr_t a2, input size_t s2,
                                input strobe_t st2, input word_t w2);
        int n;
        // shadow updated in program order with port 1 first
        if (use1) begin
            exp_d1.push_back({st1 == 0, ref_read(a1)});
            if (st1 != 0) shadow_write(a1, st1, w1);
        end
        if (use2) begin
            exp_d2.push_back({st2 == 0, ref_read(a2)});
            if (st2 != 0) shadow_write(a2, st2, w2);
        end
        @(posedge clk);
        d1_req_valid <= use1;
        d1_req_addr <= a1;
        d1_req_size <= s1;
        d1_req_strobe <= st1;
        d1_req_data <= w1;
        d2_req_valid <= use2;
        d2_req_addr <= a2;
        d2_req_size <= s2;
        d2_req_strobe <= st2;
        d2_req_data <= w2;
        if (use1) begin
            n = 0;
            do begin
                @(negedge clk);
                if (d2_resp_data_ok) fail_now("port 2 finished before port 1");
                if (++n > TIMEOUT) fail_now("timeout waiting for port 1 data_ok");
            end while (!d1_resp_data_ok);
            if (chk_bus) verify_request(a1, s1, st1);
            @(posedge clk);
            d1_req_valid <= 1'b0;
        end
        if (use2) begin
            n = 0;
            do begin
                @(negedge clk);
                if (++n > TIMEOUT) fail_now("timeout waiting for port 2 data_ok");
            end while (!d2_resp_data_ok);
            if (chk_bus) verify_request(a2, s2, st2);
            @(posedge clk);
            d2_req_valid <= 1'b0;
        end
    endtask

    initial begin
        int n;
        void'($urandom(32'h2da799a6));
        rst_n = 1'b0;
        ireq_valid = 1'b0;
        ireq_addr = '0;
        d1_req_valid = 1'b0;
        d1_req_addr = '0;
        d1_req_size = '0;
        d1_req_strobe = '0;
        d1_req_data = '0;
        d2_req_valid = 1'b0;
        d2_req_addr = '0;
        d2_req_size = '0;
        d2_req_strobe = '0;
        d2_req_data = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // quiet after reset then a translated fetch
        @(negedge clk);
        check_flag("creq_valid", creq_valid, 1'b0);
        check_flag("iresp_addr_ok", iresp_addr_ok, 1'b0);
        check_flag("iresp_data_ok", iresp_data_ok, 1'b0);
        check_flag("d1_resp_data_ok", d1_resp_data_ok, 1'b0);
        check_flag("d2_resp_data_ok", d2_resp_data_ok, 1'b0);
        check_flag("d1_resp_addr_ok", d1_resp_addr_ok, 1'b0);
        check_flag("d2_resp_addr_ok", d2_resp_addr_ok, 1'b0);
        fork
            issue_fetch(32'hbfc0_0000, 1'b1);
            begin
                n = 0;
                while (!creq_valid) begin
                    @(negedge clk);
                    if (++n > TIMEOUT) fail_now("timeout waiting for creq_valid");
                end
                // request shown after the first edge, grant registered at the second
                if (n != 2) fail_now("creq_valid did not rise one cycle after the fetch");
            end
        join

        // aliases of one location and an untranslated kuseg address
        issue_fetch(32'h8000_0040, 1'b1);
        issue_fetch(32'ha000_0040, 1'b1);
        issue_fetch(32'h0000_0040, 1'b1);
        issue_fetch(32'h4000_0100, 1'b1);

        // store on port 1 seen by load on port 2
        access_ports(1, 1, 32'h8000_0200, SIZE_WORD, 4'hf, 32'hcafe_f00d,
                     1, 32'ha000_0200, SIZE_WORD, 4'h0, 32'h0);

        // partial strobes merge into the word
        access_ports(1, 1, 32'h8000_0300, SIZE_BYTE, 4'b0100, 32'h00ab_0000,
                     1, 32'h8000_0300, SIZE_HALF, 4'b0011, 32'h0000_1234);
        access_ports(1, 1, 32'h8000_0300, SIZE_WORD, 4'h0, 32'h0,
                     0, 32'h0, SIZE_WORD, 4'h0, 32'h0);

        // fetch and data together under random stalls
        for (int i = 0; i < 24; i++) begin
            fork
                issue_fetch(32'hbfc0_1000 + 4 * i, 1'b0);
                access_ports(0, 1, 32'h8000_2000 + 4 * ($urandom % 8), SIZE_WORD,
                             strobe_t'($urandom), $urandom,
                             1, 32'ha000_2000 + 4 * ($urandom % 8), SIZE_WORD,
                             ($urandom % 2) ? strobe_t'($urandom) : 4'h0, $urandom);
            join
        end

        repeat (2) @(posedge clk);
        if (exp_i.size() == 0 && exp_d1.size() == 0 && exp_d2.size() == 0) begin
            $display("TEST OK");
        end else begin
            fail_now("responses still outstanding at end of test");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
hdl/bus_pkg.sv
hdl/ibus_to_cbus.sv
hdl/dbus_pair_sequencer.sv
hdl/cbus_arbiter.sv
hdl/mem_top.sv
verif/mem_top_sva.sv
verif/mem_top_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the mem_top testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module mem_top_tb \
    -Mdir obj_dir -o mem_top_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/mem_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    echo "Failure found in $LOG"
    exit 1
fi

exit 0
